/* source/resize_macros.svh */
`ifndef RESIZE_MACROS_SVH
`define RESIZE_MACROS_SVH

// Camera frame in pixels
`define FRAME_WIDTH       640
`define FRAME_HEIGHT      480

// One thumbnail pixel covers this block
`define BLOCK_WIDTH       20
`define BLOCK_HEIGHT      15
`define BLOCK_PIXELS      300

`define THUMB_SIZE        32
`define THUMB_PIXELS      1024

`define FRAME_ADDR_WIDTH  19  // 307200 locations
`define SUM_WIDTH         17  // Max block sum 76500

// floor(sum * 111849 >> 25) == floor(sum / 300) for sum <= 76500
`define RECIP_MULT        111849
`define RECIP_SHIFT       25

`endif

/* source/resizePkg.sv */
`default_nettype none
`include "resize_macros.svh"

package resizePkg;

    typedef logic [7:0] pixel_t;                          // Grayscale byte
    typedef logic [`FRAME_ADDR_WIDTH-1:0] frameAddr_t;    // row * 640 + column
    typedef logic [`SUM_WIDTH-1:0] blockSum_t;
    typedef logic [9:0] thumbIndex_t;                     // blockRow * 32 + blockCol

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN
    } resizeState_e;

endpackage

`default_nettype wire

/* source/frameBuffer.sv */
`default_nettype none
`include "resize_macros.svh"

// Behavioural stand-in for the SDRAM frame store
module frameBuffer (
    input  wire                    clk,
    input  wire                    frameWrEn,
    input  wire resizePkg::frameAddr_t frameWrAddr,
    input  wire resizePkg::pixel_t frameWrPix,
    input  wire                    rdEn,
    input  wire resizePkg::frameAddr_t rdAddr,
    output resizePkg::pixel_t      rdPix
);

    import resizePkg::*;

    pixel_t mem [0:`FRAME_WIDTH*`FRAME_HEIGHT-1];

    // Host load port
    always_ff @(posedge clk) begin
        if (frameWrEn) begin
            mem[frameWrAddr] <= frameWrPix;
        end
    end

    // Data appears the cycle after the strobe
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdPix <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

/* source/resizeController.sv */
`default_nettype none
`include "resize_macros.svh"

module resizeController (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                start,
    input  wire                frameDone,
    output logic               rdEn,
    output resizePkg::frameAddr_t rdAddr,
    output logic               blockLast,
    output logic               busy,
    output logic               resizeDone
);

    import resizePkg::*;

    resizeState_e state;
    resizeState_e nextState;

    logic [4:0] colCnt;        // Column inside block, 0..19
    logic [3:0] rowCnt;        // Line inside block, 0..14
    logic [4:0] blockCol;
    logic [4:0] blockRow;
    frameAddr_t blockBase;     // Top-left pixel of current block
    frameAddr_t rowBase;       // Top-left pixel of current block row

    logic lastCol;
    logic lastRow;
    logic frameLastPix;

    assign lastCol = (colCnt == 5'(`BLOCK_WIDTH - 1));
    assign lastRow = (rowCnt == 4'(`BLOCK_HEIGHT - 1));
    assign blockLast = rdEn && lastCol && lastRow;
    assign frameLastPix = blockLast && (blockCol == 5'(`THUMB_SIZE - 1))
                       && (blockRow == 5'(`THUMB_SIZE - 1));

    assign busy = (state != IDLE);

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (start) begin
                    nextState = READ;
                end
            end
            READ: begin
                if (frameLastPix) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                // Wait for the averager to flush its last block
                if (frameDone) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            resizeDone <= 1'b0;
        end else begin
            state <= nextState;
            resizeDone <= (state == DRAIN) && frameDone;
        end
    end

    // Block walk, one read per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdEn <= 1'b0;
            rdAddr <= '0;
            colCnt <= '0;
            rowCnt <= '0;
            blockCol <= '0;
            blockRow <= '0;
            blockBase <= '0;
            rowBase <= '0;
        end else if (state == IDLE) begin
            if (start) begin
                rdEn <= 1'b1;
                rdAddr <= '0;
                colCnt <= '0;
                rowCnt <= '0;
                blockCol <= '0;
                blockRow <= '0;
                blockBase <= '0;
                rowBase <= '0;
            end
        end else if (state == READ) begin
            if (frameLastPix) begin
                rdEn <= 1'b0;
            end else if (lastCol) begin
                colCnt <= '0;
                if (lastRow) begin
                    rowCnt <= '0;
                    blockCol <= blockCol + 5'd1;   // Wraps to 0 after 31
                    if (blockCol == 5'(`THUMB_SIZE - 1)) begin
                        // Down 15 lines to the next block row
                        blockRow <= blockRow + 5'd1;
                        rowBase <= rowBase + frameAddr_t'(`FRAME_WIDTH * `BLOCK_HEIGHT);
                        blockBase <= rowBase + frameAddr_t'(`FRAME_WIDTH * `BLOCK_HEIGHT);
                        rdAddr <= rowBase + frameAddr_t'(`FRAME_WIDTH * `BLOCK_HEIGHT);
                    end else begin
                        blockBase <= blockBase + frameAddr_t'(`BLOCK_WIDTH);
                        rdAddr <= blockBase + frameAddr_t'(`BLOCK_WIDTH);
                    end
                end else begin
                    rowCnt <= rowCnt + 4'd1;
                    // Back to column 0 of the block, one line down
                    rdAddr <= rdAddr + frameAddr_t'(`FRAME_WIDTH - `BLOCK_WIDTH + 1);
                end
            end else begin
                colCnt <= colCnt + 5'd1;
                rdAddr <= rdAddr + frameAddr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* source/blockAverager.sv */
`default_nettype none
`include "resize_macros.svh"

module blockAverager (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    rdEn,
    input  wire                    blockLast,
    input  wire resizePkg::pixel_t rdPix,
    output logic                   thumbWrEn,
    output resizePkg::thumbIndex_t thumbWrIndex,
    output resizePkg::pixel_t      thumbWrPix,
    output logic                   frameDone
);

    import resizePkg::*;

    logic rdEnD;          // Strobe aligned with rdPix
    logic blockLastD;
    logic sumValid;

    blockSum_t acc;
    blockSum_t accNext;
    blockSum_t blockSum;  // Completed sum waiting for the multiply

    logic [2*`SUM_WIDTH-1:0] product;

    assign accNext = acc + blockSum_t'(rdPix);

    // Mean is the top byte above the reciprocal shift
    assign thumbWrPix = product[`RECIP_SHIFT +: 8];

    assign frameDone = thumbWrEn && (thumbWrIndex == thumbIndex_t'(`THUMB_PIXELS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdEnD <= 1'b0;
            blockLastD <= 1'b0;
            sumValid <= 1'b0;
            thumbWrEn <= 1'b0;
            acc <= '0;
            thumbWrIndex <= '0;
        end else begin
            rdEnD <= rdEn;
            blockLastD <= blockLast;
            sumValid <= blockLastD;
            thumbWrEn <= sumValid;     // Product ready one cycle after the sum
            if (rdEnD) begin
                // Clear on the block's last pixel so the next block starts fresh
                acc <= blockLastD ? '0 : accNext;
            end
            if (thumbWrEn) begin
                thumbWrIndex <= thumbWrIndex + 10'd1;   // Wraps for the next frame
            end
        end
    end

    // Divide pipeline, runs alongside accumulation of the next block
    always_ff @(posedge clk) begin
        if (blockLastD) begin
            blockSum <= accNext;
        end
        if (sumValid) begin
            product <= (2*`SUM_WIDTH)'(blockSum) * (2*`SUM_WIDTH)'(`RECIP_MULT);
        end
    end

endmodule

`default_nettype wire

/* source/thumbnailStore.sv */
`default_nettype none
`include "resize_macros.svh"

module thumbnailStore (
    input  wire                         clk,
    input  wire                         thumbWrEn,
    input  wire resizePkg::thumbIndex_t thumbWrIndex,
    input  wire resizePkg::pixel_t      thumbWrPix,
    input  wire resizePkg::thumbIndex_t thumbRdAddr,
    output resizePkg::pixel_t           thumbRdPix
);

    import resizePkg::*;

    pixel_t mem [0:`THUMB_PIXELS-1];   // Row-major 32 x 32

    // Averager results
    always_ff @(posedge clk) begin
        if (thumbWrEn) begin
            mem[thumbWrIndex] <= thumbWrPix;
        end
    end

    // Host readback, one cycle latency
    always_ff @(posedge clk) begin
        thumbRdPix <= mem[thumbRdAddr];
    end

endmodule

`default_nettype wire

/* source/imageResizeTop.sv */
`default_nettype none

module imageResizeTop (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire                         frameWrEn,
    input  wire resizePkg::frameAddr_t  frameWrAddr,
    input  wire resizePkg::pixel_t      frameWrPix,
    input  wire resizePkg::thumbIndex_t thumbRdAddr,
    output logic                        busy,
    output logic                        resizeDone,
    output resizePkg::pixel_t           thumbRdPix
);

    import resizePkg::*;

    logic        rdEn;
    frameAddr_t  rdAddr;
    logic        blockLast;
    pixel_t      rdPix;
    logic        thumbWrEn;
    thumbIndex_t thumbWrIndex;
    pixel_t      thumbWrPix;
    logic        frameDone;     // Last thumbnail pixel written

    frameBuffer frameBufferInst (
        .clk         (clk),
        .frameWrEn   (frameWrEn),
        .frameWrAddr (frameWrAddr),
        .frameWrPix  (frameWrPix),
        .rdEn        (rdEn),
        .rdAddr      (rdAddr),
        .rdPix       (rdPix)
    );

    resizeController resizeControllerInst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .frameDone  (frameDone),
        .rdEn       (rdEn),
        .rdAddr     (rdAddr),
        .blockLast  (blockLast),
        .busy       (busy),
        .resizeDone (resizeDone)
    );

    blockAverager blockAveragerInst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdEn         (rdEn),
        .blockLast    (blockLast),
        .rdPix        (rdPix),
        .thumbWrEn    (thumbWrEn),
        .thumbWrIndex (thumbWrIndex),
        .thumbWrPix   (thumbWrPix),
        .frameDone    (frameDone)
    );

    thumbnailStore thumbnailStoreInst (
        .clk          (clk),
        .thumbWrEn    (thumbWrEn),
        .thumbWrIndex (thumbWrIndex),
        .thumbWrPix   (thumbWrPix),
        .thumbRdAddr  (thumbRdAddr),
        .thumbRdPix   (thumbRdPix)
    );

endmodule

`default_nettype wire

/* tests/tb_imageResize.sv */
`default_nettype none
`include "resize_macros.svh"

module tb_imageResize;

    import resizePkg::*;

    localparam int FRAME_PIXELS = `FRAME_WIDTH * `FRAME_HEIGHT;

    // Cycle budget of the whole sequence
    localparam int LOAD_CYCLES = FRAME_PIXELS + 2;
    localparam int RESIZE_CYCLES = FRAME_PIXELS + 8;
    localparam int READBACK_CYCLES = 2 * `THUMB_PIXELS + 4;
    localparam int QUIET_CYCLES = 400000;       // No second resizeDone in this window
    // Four loads, five resizes with readback, one quiet window, plus slack
    localparam int CYCLE_LIMIT = 4 * LOAD_CYCLES + 5 * (RESIZE_CYCLES + READBACK_CYCLES)
                               + QUIET_CYCLES + 20000;
    localparam logic [15:0] LFSR_SEED = 16'd6031;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        frameWrEn;
    frameAddr_t  frameWrAddr;
    pixel_t      frameWrPix;
    thumbIndex_t thumbRdAddr;
    logic        busy;
    logic        resizeDone;
    pixel_t      thumbRdPix;

    pixel_t      frame [0:FRAME_PIXELS-1];     // Model of the frame buffer contents
    logic [15:0] lfsrState;
    int          checkErrors;
    int          compareErrors;
    int          reqCount;                     // Readback requests from the main sequence
    int          ackCount;                     // Readbacks finished
    int          testsPassed;
    int          testsFailed;
    int          cycleCount;

    imageResizeTop UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .frameWrEn   (frameWrEn),
        .frameWrAddr (frameWrAddr),
        .frameWrPix  (frameWrPix),
        .thumbRdAddr (thumbRdAddr),
        .busy        (busy),
        .resizeDone  (resizeDone),
        .thumbRdPix  (thumbRdPix)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the test sequence never completed", cycleCount);
        $display("Simulation failed");
        $finish;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic nextRandomByte(output pixel_t value);
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsrState = lfsrStep(lfsrState);    // One step per bit
            value = {value[6:0], lfsrState[0]};
        end
    endtask

    // Floor of the 20 x 15 block sum over 300
    function automatic pixel_t blockMean(input int index);
        int blockRow;
        int blockCol;
        int base;
        int sum;
        blockRow = index / `THUMB_SIZE;
        blockCol = index % `THUMB_SIZE;
        base = blockRow * `BLOCK_HEIGHT * `FRAME_WIDTH + blockCol * `BLOCK_WIDTH;
        sum = 0;
        for (int r = 0; r < `BLOCK_HEIGHT; r++) begin
            for (int c = 0; c < `BLOCK_WIDTH; c++) begin
                sum += int'(frame[base + r * `FRAME_WIDTH + c]);
            end
        end
        return pixel_t'(sum / `BLOCK_PIXELS);
    endfunction

    task automatic fillUniform(input pixel_t value);
        for (int a = 0; a < FRAME_PIXELS; a++) begin
            frame[a] = value;
        end
    endtask

    task automatic fillGradient();
        for (int r = 0; r < `FRAME_HEIGHT; r++) begin
            for (int c = 0; c < `FRAME_WIDTH; c++) begin
                frame[r * `FRAME_WIDTH + c] = pixel_t'((r + c) % 256);
            end
        end
    endtask

    task automatic fillRandom();
        pixel_t value;
        for (int a = 0; a < FRAME_PIXELS; a++) begin
            nextRandomByte(value);
            frame[a] = value;
        end
    endtask

    // Host writes, one pixel per cycle
    task automatic loadFrame();
        for (int a = 0; a < FRAME_PIXELS; a++) begin
            @(negedge clk);
            frameWrEn = 1'b1;
            frameWrAddr = frameAddr_t'(a);
            frameWrPix = frame[a];
        end
        @(negedge clk);
        frameWrEn = 1'b0;
    endtask

    task automatic startResize();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // Bounded by the watchdog
    task automatic waitForDone();
        while (resizeDone !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic requestCompare();
        reqCount++;
        wait (ackCount == reqCount);
    endtask

    task automatic resizeAndCheck();
        startResize();
        waitForDone();
        requestCompare();
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        int newErrors;
        newErrors = checkErrors + compareErrors - errorsBefore;
        if (newErrors == 0) begin
            testsPassed++;
            $display("Test %s: PASS", name);
        end else begin
            testsFailed++;
            $display("Test %s: FAIL with %0d errors", name, newErrors);
        end
    endtask

    // Thumbnail readback against the reference
    initial begin
        pixel_t expected;
        thumbRdAddr = '0;
        compareErrors = 0;
        forever begin
            wait (reqCount != ackCount);
            for (int i = 0; i < `THUMB_PIXELS; i++) begin
                @(negedge clk);
                thumbRdAddr = thumbIndex_t'(i);
                expected = blockMean(i);
                @(negedge clk);   // One cycle read latency
                assert (thumbRdPix === expected) else begin
                    $display("MISMATCH thumbRdPix index 0x%03h expected 0x%02h actual 0x%02h",
                             i, expected, thumbRdPix);
                    compareErrors++;
                end
            end
            ackCount++;
        end
    end

    initial begin
        int errorsBefore;
        int extraDone;
        rst_n = 1'b0;
        start = 1'b0;
        frameWrEn = 1'b0;
        frameWrAddr = '0;
        frameWrPix = '0;
        lfsrState = LFSR_SEED;
        checkErrors = 0;
        testsPassed = 0;
        testsFailed = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errorsBefore = checkErrors + compareErrors;
        repeat (10) begin
            @(negedge clk);
            assert (busy === 1'b0) else begin
                $display("MISMATCH busy expected 0x0 actual 0x%0h", busy);
                checkErrors++;
            end
            assert (resizeDone === 1'b0) else begin
                $display("MISMATCH resizeDone expected 0x0 actual 0x%0h", resizeDone);
                checkErrors++;
            end
        end
        reportTest("1 reset state", errorsBefore);

        errorsBefore = checkErrors + compareErrors;
        fillUniform(8'hFF);       // Largest possible block sum
        loadFrame();
        resizeAndCheck();
        reportTest("2 uniform full-scale frame", errorsBefore);

        errorsBefore = checkErrors + compareErrors;
        fillGradient();
        loadFrame();
        resizeAndCheck();
        reportTest("3 gradient frame", errorsBefore);

        errorsBefore = checkErrors + compareErrors;
        fillRandom();
        loadFrame();
        resizeAndCheck();
        reportTest("4 random frame", errorsBefore);

        // Resize the same frame again, with a start pulse while busy
        errorsBefore = checkErrors + compareErrors;
        startResize();
        repeat (1000) @(negedge clk);
        assert (busy === 1'b1) else begin
            $display("MISMATCH busy expected 0x1 actual 0x%0h", busy);
            checkErrors++;
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        waitForDone();
        @(negedge clk);
        assert (busy === 1'b0) else begin
            $display("MISMATCH busy expected 0x0 actual 0x%0h", busy);
            checkErrors++;
        end
        extraDone = 0;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (resizeDone === 1'b1) begin
                extraDone++;
            end
        end
        assert (extraDone == 0) else begin
            $display("The start pulse during busy was not ignored, %0d extra resizeDone pulses",
                     extraDone);
            checkErrors++;
        end
        requestCompare();
        fillRandom();             // Fresh frame, index must wrap to zero
        loadFrame();
        resizeAndCheck();
        reportTest("5 busy and start", errorsBefore);

        $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                 testsPassed, testsFailed, checkErrors + compareErrors);
        if (testsFailed == 0 && checkErrors + compareErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/resizePkg.sv
source/frameBuffer.sv
source/resizeController.sv
source/blockAverager.sv
source/thumbnailStore.sv
source/imageResizeTop.sv
tests/tb_imageResize.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the image resize testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_imageResize \
    -Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation run returned status $runStatus"
    exit 1
fi

if grep -qx "Simulation passed" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1
